// File: mipsTests.txt
# test <name>, then p <addr> <word> program, d <addr> <word> data,
# e <addr> <word> expected store in order, end closes the test
test aluOps
p 000 24010005
p 004 2402FFFD
p 008 00221821
p 00C AC030100
p 010 0041202A
p 014 AC040104
p 018 3C051234
p 01C 34A5FF00
p 020 AC050108
p 024 00223007
p 028 AC06010C
p 02C 0800000B
e 100 00000002
e 104 00000001
e 108 1234FF00
e 10C FFFFFFFF
end
test loadStore
p 000 8C010180
p 004 AC010190
p 008 08000002
d 180 CAFEF00D
e 190 CAFEF00D
end
test branchJump
p 000 24010007
p 004 10200001
p 008 AC010100
p 00C 14200001
p 010 AC000100
p 014 0C000008
p 018 AC000104
p 020 AC1F0104
p 024 08000009
e 100 00000007
e 104 0000001C
end
test overflowTrap
p 000 3C017FFF
p 004 24020055
p 008 00211020
p 1C0 AC020100
p 1C4 00211821
p 1C8 AC030104
p 1CC 08000073
e 100 00000055
e 104 FFFE0000
end

// File: compile.f
cpuPkg.sv
instructionDecoder.sv
alu.sv
registerFile.sv
dataPath.sv
controlUnit.sv
mipsCore.sv
mipsCoreAssertions.sv
tbMipsCore.sv

// File: runSim.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tbMipsCore -f compile.f -o simTb

./obj_dir/simTb 2>&1 | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
	echo "Simulation failed"
	exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi

// File: tbMipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module tbMipsCore
	import cpuPkg::*;
();

	localparam int memWordCount = 128; // 512 bytes
	localparam int cyclesPerWord = 60;

	logic Clk;
	logic rstN;
	memReq mem;
	memRsp memIn;

	// Parsed test file, one entry per p/d/e line
	string testNames[$];
	int entryTest[$];
	int entryKind[$]; // 0 program, 1 data, 2 expected write
	logic [31:0] entryAddr[$];
	logic [31:0] entryData[$];
	int totalWords;
	logic parseDone;
	logic fileOk;

	logic [31:0] memWords [memWordCount];
	logic [31:0] expAddr[$];
	logic [31:0] expData[$];
	int expIdx;
	int testErrors;
	string curName;
	logic testDone;

	logic pending;
	int waitLeft;
	logic haveFetch;
	logic [addrWidth-1:0] lastFetch;
	logic firstReq;

	mipsCore dut (
		.Clk(Clk),
		.rstN(rstN),
		.mem(mem),
		.memIn(memIn)
	);

	always #5 Clk = ~Clk;

	task automatic readTests();
		int fd;
		int rc;
		int testIdx;
		string line;
		string kw;
		string name;
		logic [31:0] a;
		logic [31:0] d;
		testIdx = -1;
		fileOk = 1'b1;
		fd = $fopen("mipsTests.txt", "r");
		if (fd == 0) begin
			$display("Could not open the test file mipsTests.txt");
			fileOk = 1'b0;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				rc = $fgets(line, fd);
				if (line.len() < 2 || line.substr(0, 0) == "#")
					continue;
				kw = "";
				rc = $sscanf(line, "%s", kw);
				if (kw == "test") begin
					rc = $sscanf(line, "%s %s", kw, name);
					testNames.push_back(name);
					testIdx++;
				end else if (kw == "p" || kw == "d" || kw == "e") begin
					rc = $sscanf(line, "%s %h %h", kw, a, d);
					if (rc != 3) begin
						$display("Malformed line in mipsTests.txt: %s", line);
						fileOk = 1'b0;
					end
					entryTest.push_back(testIdx);
					entryKind.push_back(kw == "p" ? 0 : (kw == "d" ? 1 : 2));
					entryAddr.push_back(a);
					entryData.push_back(d);
					if (kw == "p")
						totalWords++;
				end
			end
			$fclose(fd);
		end
	endtask

	// Fill pattern decodes as an invalid opcode
	task automatic loadMemory(input int t);
		for (int i = 0; i < memWordCount; i++) begin
			memWords[i] = 32'hfc00_0000 | 32'(i * 4);
		end
		expAddr.delete();
		expData.delete();
		for (int i = 0; i < entryTest.size(); i++) begin
			if (entryTest[i] == t) begin
				if (entryKind[i] == 2) begin
					expAddr.push_back(entryAddr[i]);
					expData.push_back(entryData[i]);
				end else begin
					memWords[entryAddr[i][8:2]] = entryData[i];
				end
			end
		end
	endtask

	task automatic checkStore(input logic [31:0] a, input logic [31:0] d);
		assert (expIdx < expAddr.size()) else begin
			$display("%s: unexpected extra write of %h to address %h", curName, d, a);
			testErrors++;
		end
		if (expIdx < expAddr.size()) begin
			assert (a == expAddr[expIdx] && d == expData[expIdx]) else begin
				$display("[ERROR] %s: expected %h at %h, actual %h at %h", curName,
					expData[expIdx], expAddr[expIdx], d, a);
				testErrors++;
			end
			expIdx++;
		end
	endtask

	task automatic startRequest();
		logic isFetch;
		isFetch = (dut.control.state == fetchReq);
		if (firstReq) begin
			assert (mem.addr == '0 && !mem.rw) else begin
				$display("%s: first request after reset was not a read of address 0",
					curName);
				testErrors++;
			end
			firstReq = 1'b0;
		end
		if (isFetch) begin
			if (haveFetch && lastFetch == mem.addr)
				testDone = 1'b1; // Jump to self
			lastFetch = mem.addr;
			haveFetch = 1'b1;
		end
		if (!testDone) begin
			pending = 1'b1;
			waitLeft = 1 + int'($urandom % 4);
		end
	endtask

	// Memory model with random latency
	always @(posedge Clk) begin
		if (!rstN) begin
			assert (!mem.mfa) else begin
				$display("%s: mfa was high while reset was asserted", curName);
				testErrors++;
			end
			pending = 1'b0;
			haveFetch = 1'b0;
			firstReq = 1'b1;
			memIn.mfc <= 1'b0;
		end else if (memIn.mfc) begin
			memIn.mfc <= 1'b0;
		end else if (!pending) begin
			if (mem.mfa && !testDone)
				startRequest();
		end else begin
			waitLeft--;
			if (waitLeft == 0) begin
				if (mem.rw) begin
					memWords[mem.addr[8:2]] = mem.wdata;
					checkStore(32'(mem.addr), mem.wdata);
				end
				memIn.rdata <= memWords[mem.addr[8:2]];
				memIn.mfc <= 1'b1;
				pending = 1'b0;
			end
		end
	end

	initial begin
		int limit;
		wait (parseDone);
		limit = cyclesPerWord * totalWords;
		repeat (limit) @(posedge Clk);
		$display("Timeout: the run did not finish within %0d cycles", limit);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		int passed;
		int failed;
		Clk = 1'b0;
		rstN <= 1'b0;
		memIn <= '0;
		parseDone = 1'b0;
		testDone = 1'b1;
		totalWords = 0;
		pending = 1'b0;
		passed = 0;
		failed = 0;
		curName = "init";
		void'($urandom(32'hf343_8c18));
		readTests();

		if (!fileOk) begin
			$display("=== FAIL ===");
		end else begin
			parseDone = 1'b1;
			for (int t = 0; t < testNames.size(); t++) begin
				@(posedge Clk);
				rstN <= 1'b0;
				@(posedge Clk);
				curName = testNames[t];
				loadMemory(t);
				expIdx = 0;
				testErrors = 0;
				testDone = 1'b0;
				@(posedge Clk);
				rstN <= 1'b1; // Two cycles of reset
				wait (testDone);
				assert (expIdx == expAddr.size()) else begin
					$display("%s: %0d expected writes never happened", curName,
						expAddr.size() - expIdx);
					testErrors++;
				end
				$display("%s: %s, %0d of %0d writes", curName,
					testErrors == 0 ? "ok" : "failed", expIdx, expAddr.size());
				if (testErrors == 0)
					passed++;
				else
					failed++;
			end

			$display("%0d tests, %0d passed, %0d failed", testNames.size(), passed, failed);
			if (failed == 0 && testNames.size() > 0) begin
				$display("=== PASS ===");
			end else begin
				$display("=== FAIL ===");
			end
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: mipsCoreAssertions.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCoreAssertions
	import cpuPkg::*;
(
	input logic Clk,
	input logic rstN,
	input memReq mem,
	input memRsp memIn
);

	// Request held steady until completion
	reqStable: assert property (@(posedge Clk) disable iff (!rstN)
		mem.mfa && !memIn.mfc |=> mem.mfa && $stable(mem.rw) && $stable(mem.addr))
		else $error("memory request changed before mfc");

	writeDataStable: assert property (@(posedge Clk) disable iff (!rstN)
		mem.mfa && mem.rw && !memIn.mfc |=> $stable(mem.wdata))
		else $error("write data changed before mfc");

	dropAfterMfc: assert property (@(posedge Clk) disable iff (!rstN)
		memIn.mfc |=> !mem.mfa)
		else $error("mfa still high in the cycle after mfc");

	quietInReset: assert property (@(posedge Clk) !rstN |-> !mem.mfa)
		else $error("mfa high during reset");

endmodule

bind mipsCore mipsCoreAssertions checks (
	.Clk(Clk),
	.rstN(rstN),
	.mem(mem),
	.memIn(memIn)
);

`default_nettype wire

// File: mipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCore
	import cpuPkg::*;
(
	input logic Clk,
	input logic rstN,
	output memReq mem,
	input memRsp memIn
);

	ctrlBundle ctrl;
	decodedInstr instr;
	aluFlags flags;

	controlUnit control (
		.Clk(Clk),
		.rstN(rstN),
		.instr(instr),
		.flags(flags),
		.mfc(memIn.mfc),
		.ctrl(ctrl),
		.mfa(mem.mfa),
		.rw(mem.rw)
	);

	dataPath path (
		.Clk(Clk),
		.rstN(rstN),
		.ctrl(ctrl),
		.memIn(memIn),
		.addr(mem.addr),
		.wdata(mem.wdata),
		.instr(instr),
		.flags(flags)
	);

endmodule

`default_nettype wire

// File: controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit
	import cpuPkg::*;
(
	input logic Clk,
	input logic rstN,
	input decodedInstr instr,
	input aluFlags flags,
	input logic mfc,
	output ctrlBundle ctrl,
	output logic mfa,
	output logic rw
);

	cpuState state;
	cpuState nextState;

	aluOp execFunc;
	aluBSrc execBSel;
	logic execTraps;
	logic branchTaken;

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN)
			state <= resetState;
		else
			state <= nextState;
	end

	// ALU setup of the register ops, held over into overflowCheck
	always_comb begin
		case (instr.op)
			opAddu, opAdd, opAddiu, opAddi: execFunc = aluAdd;
			opSubu, opSub: execFunc = aluSub;
			opAnd, opAndi: execFunc = aluAnd;
			opOr, opOri: execFunc = aluOr;
			opXor, opXori: execFunc = aluXor;
			opNor: execFunc = aluNor;
			opSllv: execFunc = aluSll;
			opSrlv: execFunc = aluSrl;
			opSrav: execFunc = aluSra;
			opLui: execFunc = aluLui;
			opSlt, opSlti: execFunc = aluSlt;
			opSltu, opSltiu: execFunc = aluSltu;
			default: execFunc = aluPass;
		endcase
	end

	assign execBSel = (instr.op inside {opAddu, opAdd, opSubu, opSub, opAnd, opOr, opXor,
		opNor, opSlt, opSltu, opSllv, opSrlv, opSrav}) ? bReg : bImm;
	assign execTraps = instr.op inside {opAdd, opAddi, opSub};
	assign branchTaken = (instr.op == opBeq) ? flags.zero : !flags.zero;

	always_comb begin
		nextState = state;
		ctrl = '0;
		mfa = 1'b0;
		rw = 1'b0;
		unique case (state)
			resetState: nextState = fetchAddr;
			fetchAddr: begin
				ctrl.marLoad = 1'b1;
				ctrl.marSrc = marFromPc;
				nextState = fetchReq;
			end
			fetchReq: begin
				mfa = 1'b1;
				nextState = fetchWait;
			end
			fetchWait: begin
				mfa = 1'b1;
				if (mfc) begin // rdata only valid now
					ctrl.mdrLoad = 1'b1;
					ctrl.mdrSrc = mdrFromMem;
					nextState = loadIr;
				end
			end
			loadIr: begin
				ctrl.irLoad = 1'b1;
				ctrl.pcLoad = 1'b1; // PC + 4
				ctrl.pcSrc = pcFromAlu;
				ctrl.aluFunc = aluIncr4;
				ctrl.aluBSel = bPc;
				nextState = decode;
			end
			decode: begin
				case (instr.op)
					opLw, opSw: nextState = memAddr;
					opBeq, opBne: nextState = branch;
					opJ, opJal: nextState = jump;
					opInvalid: nextState = fetchAddr; // Skipped
					default: nextState = execute;
				endcase
			end
			execute: begin
				ctrl.aluFunc = execFunc;
				ctrl.aluBSel = execBSel;
				ctrl.regWrite = !execTraps; // Trapping ops write after the check
				nextState = execTraps ? overflowCheck : fetchAddr;
			end
			overflowCheck: begin
				ctrl.aluFunc = execFunc;
				ctrl.aluBSel = execBSel;
				if (flags.overflow) begin
					nextState = trap;
				end else begin
					ctrl.regWrite = 1'b1;
					nextState = fetchAddr;
				end
			end
			memAddr: begin
				ctrl.marLoad = 1'b1;
				ctrl.marSrc = marFromAlu;
				ctrl.aluFunc = aluAdd; // rs + offset
				ctrl.aluBSel = bImm;
				nextState = (instr.op == opSw) ? storeData : loadReq;
			end
			loadReq: begin
				mfa = 1'b1;
				nextState = loadWait;
			end
			loadWait: begin
				mfa = 1'b1;
				if (mfc) begin
					ctrl.mdrLoad = 1'b1;
					ctrl.mdrSrc = mdrFromMem;
					nextState = loadWrite;
				end
			end
			loadWrite: begin
				ctrl.regWrite = 1'b1;
				ctrl.wbSel = wbMdr;
				nextState = fetchAddr;
			end
			storeData: begin
				ctrl.mdrLoad = 1'b1; // rt through the ALU
				ctrl.mdrSrc = mdrFromAlu;
				ctrl.aluFunc = aluPass;
				ctrl.aluBSel = bReg;
				nextState = storeReq;
			end
			storeReq: begin
				mfa = 1'b1;
				rw = 1'b1;
				nextState = storeWait;
			end
			storeWait: begin
				mfa = 1'b1;
				rw = 1'b1;
				if (mfc)
					nextState = fetchAddr;
			end
			branch: begin
				ctrl.aluFunc = aluSub; // Zero flag compares rs and rt
				ctrl.aluBSel = bReg;
				ctrl.pcLoad = branchTaken;
				ctrl.pcSrc = pcFromBranch;
				nextState = fetchAddr;
			end
			jump: begin
				ctrl.pcLoad = 1'b1;
				ctrl.pcSrc = pcFromJump;
				if (instr.op == opJal) begin
					ctrl.regWrite = 1'b1; // Link reads the old PC
					ctrl.regDstSel = 1'b1;
					ctrl.aluFunc = aluIncr4;
					ctrl.aluBSel = bPc;
				end
				nextState = fetchAddr;
			end
			trap: begin
				ctrl.pcLoad = 1'b1;
				ctrl.pcSrc = pcFromTrap;
				nextState = fetchAddr;
			end
			default: nextState = resetState;
		endcase
	end

endmodule

`default_nettype wire

// File: dataPath.sv
`timescale 1ns/1ps
`default_nettype none

module dataPath
	import cpuPkg::*;
(
	input logic Clk,
	input logic rstN,
	input ctrlBundle ctrl,
	input memRsp memIn,
	output logic [addrWidth-1:0] addr,
	output logic [dataWidth-1:0] wdata,
	output decodedInstr instr,
	output aluFlags flags
);

	logic [addrWidth-1:0] pc;
	logic [addrWidth-1:0] mar;
	logic [dataWidth-1:0] ir;
	logic [dataWidth-1:0] mdr;

	logic [dataWidth-1:0] rsData;
	logic [dataWidth-1:0] rtData;
	logic [dataWidth-1:0] aluB;
	logic [dataWidth-1:0] aluY;
	logic [dataWidth-1:0] wbData;
	logic [regIdxWidth-1:0] wrIdx;

	logic [addrWidth-1:0] branchTarget;
	logic [addrWidth-1:0] jumpTarget;
	logic [addrWidth-1:0] pcNext;

	instructionDecoder decoder (
		.ir(ir),
		.instr(instr)
	);

	registerFile regFile (
		.Clk(Clk),
		.rstN(rstN),
		.we(ctrl.regWrite),
		.rs(instr.rs),
		.rt(instr.rt),
		.rd(wrIdx),
		.wd(wbData),
		.rsData(rsData),
		.rtData(rtData)
	);

	alu aluUnit (
		.func(ctrl.aluFunc),
		.a(rsData),
		.b(aluB),
		.y(aluY),
		.flags(flags)
	);

	always_comb begin
		unique case (ctrl.aluBSel)
			bReg: aluB = rtData;
			bImm: aluB = instr.imm;
			bPc: aluB = dataWidth'(pc);
			default: aluB = rtData;
		endcase
	end

	assign wrIdx = ctrl.regDstSel ? linkReg : instr.rd;
	assign wbData = (ctrl.wbSel == wbMdr) ? mdr : aluY;

	// PC already points past the branch, wraps at 512 bytes
	assign branchTarget = pc + {instr.imm[addrWidth-3:0], 2'b00};
	assign jumpTarget = {instr.jumpIndex[addrWidth-3:0], 2'b00};

	always_comb begin
		unique case (ctrl.pcSrc)
			pcFromAlu: pcNext = aluY[addrWidth-1:0];
			pcFromBranch: pcNext = branchTarget;
			pcFromJump: pcNext = jumpTarget;
			pcFromTrap: pcNext = trapVector;
			default: pcNext = aluY[addrWidth-1:0];
		endcase
	end

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
			ir <= '0;
		end else begin
			if (ctrl.pcLoad)
				pc <= pcNext;
			if (ctrl.irLoad)
				ir <= mdr; // Fetched word arrives through MDR
		end
	end

	always_ff @(posedge Clk) begin
		if (ctrl.marLoad)
			mar <= (ctrl.marSrc == marFromAlu) ? aluY[addrWidth-1:0] : pc;
		if (ctrl.mdrLoad)
			mdr <= (ctrl.mdrSrc == mdrFromMem) ? memIn.rdata : aluY;
	end

	// Fetch goes through MAR too, so the bus address is always MAR
	assign addr = mar;
	assign wdata = mdr;

endmodule

`default_nettype wire

// File: registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile
	import cpuPkg::*;
(
	input logic Clk,
	input logic rstN,
	input logic we,
	input logic [regIdxWidth-1:0] rs,
	input logic [regIdxWidth-1:0] rt,
	input logic [regIdxWidth-1:0] rd,
	input logic [dataWidth-1:0] wd,
	output logic [dataWidth-1:0] rsData,
	output logic [dataWidth-1:0] rtData
);

	localparam int numRegs = 2 ** regIdxWidth;

	logic [dataWidth-1:0] regs [numRegs];

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (rd != '0)) begin // $zero stays zero
			regs[rd] <= wd;
		end
	end

	assign rsData = regs[rs];
	assign rtData = regs[rt];

endmodule

`default_nettype wire

// File: alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
	import cpuPkg::*;
(
	input aluOp func,
	input logic [dataWidth-1:0] a,
	input logic [dataWidth-1:0] b,
	output logic [dataWidth-1:0] y,
	output aluFlags flags
);

	localparam int msb = dataWidth - 1;

	logic [dataWidth-1:0] sum;
	logic [dataWidth-1:0] diff;
	logic [4:0] shamt;
	logic addOvf;
	logic subOvf;

	assign sum = a + b;
	assign diff = a - b;
	assign shamt = a[4:0]; // Variable shifts take the amount from rs

	// Signed overflow when the result sign disagrees with the operands
	assign addOvf = (a[msb] == b[msb]) && (sum[msb] != a[msb]);
	assign subOvf = (a[msb] != b[msb]) && (diff[msb] != a[msb]);

	always_comb begin
		unique case (func)
			aluPass: y = b;
			aluAdd: y = sum;
			aluSub: y = diff;
			aluAnd: y = a & b;
			aluOr: y = a | b;
			aluXor: y = a ^ b;
			aluNor: y = ~(a | b);
			aluSll: y = b << shamt;
			aluSrl: y = b >> shamt;
			aluSra: y = $signed(b) >>> shamt;
			aluLui: y = {b[15:0], 16'b0};
			aluSlt: y = dataWidth'($signed(a) < $signed(b));
			aluSltu: y = dataWidth'(a < b);
			aluIncr4: y = b + dataWidth'(4); // PC advance and link
			default: y = b;
		endcase
	end

	always_comb begin
		flags.zero = (y == '0);
		case (func)
			aluAdd: flags.overflow = addOvf;
			aluSub: flags.overflow = subOvf;
			default: flags.overflow = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: instructionDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instructionDecoder
	import cpuPkg::*;
(
	input logic [dataWidth-1:0] ir,
	output decodedInstr instr
);

	logic [5:0] opcode;
	logic [5:0] funct;
	instrOp op;
	logic zeroExt;
	logic [regIdxWidth-1:0] dest;
	logic [dataWidth-1:0] imm;

	assign opcode = ir[31:26];
	assign funct = ir[5:0];

	always_comb begin
		op = opInvalid;
		if (opcode == 6'b000000) begin
			case (funct)
				6'b100001: op = opAddu;
				6'b100000: op = opAdd;
				6'b100011: op = opSubu;
				6'b100010: op = opSub;
				6'b100100: op = opAnd;
				6'b100101: op = opOr;
				6'b100110: op = opXor;
				6'b100111: op = opNor;
				6'b101010: op = opSlt;
				6'b101011: op = opSltu;
				6'b000100: op = opSllv;
				6'b000110: op = opSrlv;
				6'b000111: op = opSrav;
				default: op = opInvalid;
			endcase
		end else begin
			case (opcode)
				6'b001001: op = opAddiu;
				6'b001000: op = opAddi;
				6'b001100: op = opAndi;
				6'b001101: op = opOri;
				6'b001110: op = opXori;
				6'b001010: op = opSlti;
				6'b001011: op = opSltiu;
				6'b001111: op = opLui;
				6'b100011: op = opLw;
				6'b101011: op = opSw;
				6'b000100: op = opBeq;
				6'b000101: op = opBne;
				6'b000010: op = opJ;
				6'b000011: op = opJal;
				default: op = opInvalid;
			endcase
		end
	end

	// Logical immediates are zero extended, everything else sign extended
	assign zeroExt = op inside {opAndi, opOri, opXori, opLui};
	assign imm = zeroExt ? {16'b0, ir[15:0]} : {{16{ir[15]}}, ir[15:0]};

	always_comb begin
		if (op == opJal)
			dest = linkReg;
		else if (opcode == 6'b000000)
			dest = ir[15:11]; // rd
		else
			dest = ir[20:16]; // rt
	end

	assign instr = '{op: op, rs: ir[25:21], rt: ir[20:16], rd: dest, imm: imm,
		jumpIndex: ir[25:0]};

endmodule

`default_nettype wire

// File: cpuPkg.sv
`default_nettype none

package cpuPkg;

	localparam int dataWidth = 32;
	localparam int addrWidth = 9; // 512-byte memory
	localparam int regIdxWidth = 5;
	localparam int jumpIdxWidth = 26;
	localparam logic [addrWidth-1:0] trapVector = 9'd448; // Overflow trap entry
	localparam logic [regIdxWidth-1:0] linkReg = 5'd31;

	typedef enum logic [4:0] {
		resetState, fetchAddr, fetchReq, fetchWait, loadIr, decode,
		execute, overflowCheck, memAddr, loadReq, loadWait, loadWrite,
		storeData, storeReq, storeWait, branch, jump, trap
	} cpuState;

	// R-type ops first, then immediates, memory and control flow
	typedef enum logic [4:0] {
		opAddu, opAdd, opSubu, opSub, opAnd, opOr, opXor, opNor,
		opSlt, opSltu, opSllv, opSrlv, opSrav,
		opAddiu, opAddi, opAndi, opOri, opXori, opSlti, opSltiu, opLui,
		opLw, opSw, opBeq, opBne, opJ, opJal, opInvalid
	} instrOp;

	typedef enum logic [3:0] {
		aluPass, aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
		aluSll, aluSrl, aluSra, aluLui, aluSlt, aluSltu, aluIncr4
	} aluOp;

	typedef enum logic [1:0] {pcFromAlu, pcFromBranch, pcFromJump, pcFromTrap} pcSrcSel;
	typedef enum logic {marFromPc, marFromAlu} marSrcSel;
	typedef enum logic {mdrFromAlu, mdrFromMem} mdrSrcSel;
	typedef enum logic [1:0] {bReg, bImm, bPc} aluBSrc;
	typedef enum logic {wbAlu, wbMdr} wbSrc;

	typedef struct packed {
		logic mfa; // Request strobe
		logic rw; // 1 = write
		logic [addrWidth-1:0] addr;
		logic [dataWidth-1:0] wdata;
	} memReq;

	typedef struct packed {
		logic mfc; // One-cycle completion pulse
		logic [dataWidth-1:0] rdata;
	} memRsp;

	typedef struct packed {
		instrOp op;
		logic [regIdxWidth-1:0] rs;
		logic [regIdxWidth-1:0] rt;
		logic [regIdxWidth-1:0] rd; // Already the destination index
		logic [dataWidth-1:0] imm;
		logic [jumpIdxWidth-1:0] jumpIndex;
	} decodedInstr;

	typedef struct packed {
		logic pcLoad;
		pcSrcSel pcSrc;
		logic irLoad;
		logic marLoad;
		marSrcSel marSrc;
		logic mdrLoad;
		mdrSrcSel mdrSrc;
		logic regWrite;
		logic regDstSel; // Forces the link register
		aluOp aluFunc;
		aluBSrc aluBSel;
		wbSrc wbSel;
	} ctrlBundle;

	typedef struct packed {
		logic zero;
		logic overflow;
	} aluFlags;

endpackage

`default_nettype wire
